// ==== src/sdLogConsts.svh ====
// ------------------------------
// shared constants of the logger
// uart timing, sector and fifo sizes,
// directory update period, file name
// ------------------------------
`ifndef SD_LOG_CONSTS_SVH
`define SD_LOG_CONSTS_SVH

// clock and serial line
`define CLK_FREQ_HZ 50000000
`define UART_BAUD 3125000
`define CLKS_PER_BIT (`CLK_FREQ_HZ / `UART_BAUD)

// one sd block
`define SECTOR_BYTES 512

// fifo holds 2**11 = 2048 bytes
`define FIFO_DEPTH_LOG2 11

// data sectors between directory rewrites
`define UPDATE_EVERY 2

// short 8.3 directory entry
`define DIR_ENTRY_BYTES 32
`define LOG_FILE_NAME "LOG     DAT"
`define FILE_ATTR 8'h20

`endif

// ==== src/sdLogPkg.sv ====
// ------------------------------
// shared vector types and the
// controller state encoding
// ------------------------------
`include "sdLogConsts.svh"

package sdLogPkg;

  typedef logic [7:0] byteT;
  typedef logic [31:0] sectorT;
  // index inside one 512 byte sector
  typedef logic [8:0] byteIdxT;
  // one extra bit so a full fifo is representable
  typedef logic [`FIFO_DEPTH_LOG2:0] countT;
  typedef logic [31:0] clusterT;

  typedef enum logic [2:0] {
    stIdle,
    stData,
    stDataEnd,
    stDir,
    stDirEnd
  } ctrlStateT;

endpackage

// ==== src/uartRx.sv ====
// ------------------------------
// uart 8N1 receiver
// ------------------------------
`timescale 1ns/1ps
`include "sdLogConsts.svh"

module uartRx (
  input  logic           clk,
  input  logic           rstn,
  input  logic           rx,
  output sdLogPkg::byteT rxByte,
  output logic           rxValid
);

  localparam int CntW = $clog2(`CLKS_PER_BIT);
  localparam logic [CntW-1:0] HalfLast = CntW'(`CLKS_PER_BIT / 2 - 1);
  localparam logic [CntW-1:0] FullLast = CntW'(`CLKS_PER_BIT - 1);
  // bit 0 start, 1..8 data, 9 stop
  localparam logic [3:0] StopIdx = 4'd9;

  logic [1:0]      rxSync;
  logic            busy;
  logic [CntW-1:0] clkCnt;
  logic [3:0]      bitIdx;
  logic            bitTick;
  sdLogPkg::byteT  shiftReg;

  // start bit is sampled after half a bit, the rest after full bits
  assign bitTick = busy && (clkCnt == ((bitIdx == 4'd0) ? HalfLast : FullLast));

  always_ff @(posedge clk or negedge rstn) begin
    if (!rstn) begin
      rxSync  <= 2'b11;
      busy    <= 1'b0;
      clkCnt  <= '0;
      bitIdx  <= '0;
      rxValid <= 1'b0;
    end else begin
      rxSync  <= {rxSync[0], rx};
      rxValid <= 1'b0;
      if (!busy) begin
        // falling edge of the start bit
        if (!rxSync[1]) begin
          busy   <= 1'b1;
          clkCnt <= '0;
          bitIdx <= '0;
        end
      end else if (bitTick) begin
        clkCnt <= '0;
        bitIdx <= bitIdx + 4'd1;
        if ((bitIdx == 4'd0) && rxSync[1]) begin
          // glitch, not a real start bit
          busy <= 1'b0;
        end else if (bitIdx == StopIdx) begin
          busy    <= 1'b0;
          // low stop bit means framing error, frame dropped
          rxValid <= rxSync[1];
        end
      end else begin
        clkCnt <= clkCnt + 1'b1;
      end
    end
  end

  // data path, lsb arrives first
  always_ff @(posedge clk) begin
    if (bitTick && (bitIdx != 4'd0) && (bitIdx != StopIdx)) begin
      shiftReg <= {rxSync[1], shiftReg[7:1]};
    end
    if (bitTick && (bitIdx == StopIdx)) begin
      rxByte <= shiftReg;
    end
  end

  rxValidSingle: assert property (@(posedge clk) disable iff (!rstn) rxValid |=> !rxValid);

endmodule

// ==== src/byteFifo.sv ====
// ------------------------------
// byte fifo with fill count
// and sticky overflow flag
// ------------------------------
`timescale 1ns/1ps
`include "sdLogConsts.svh"

module byteFifo (
  input  logic            clk,
  input  logic            rstn,
  input  logic            push,
  input  sdLogPkg::byteT  pushData,
  input  logic            pop,
  output sdLogPkg::byteT  popData,
  output sdLogPkg::countT count,
  output logic            overflow
);

  localparam int Depth = 2 ** `FIFO_DEPTH_LOG2;

  sdLogPkg::byteT              mem [Depth];
  logic [`FIFO_DEPTH_LOG2-1:0] wrPtr;
  logic [`FIFO_DEPTH_LOG2-1:0] rdPtr;
  logic                        full;
  logic                        pushOk;
  logic                        popOk;

  // count msb only set when all Depth slots are taken
  assign full   = count[`FIFO_DEPTH_LOG2];
  assign pushOk = push && !full;
  assign popOk  = pop && (count != '0);

  always_ff @(posedge clk or negedge rstn) begin
    if (!rstn) begin
      wrPtr    <= '0;
      rdPtr    <= '0;
      count    <= '0;
      overflow <= 1'b0;
    end else begin
      if (pushOk) wrPtr <= wrPtr + 1'b1;
      if (popOk) rdPtr <= rdPtr + 1'b1;
      count <= count + pushOk - popOk;
      // uart cannot be stalled, lost byte is only flagged
      if (push && full) overflow <= 1'b1;
    end
  end

  // storage and registered head byte
  always_ff @(posedge clk) begin
    if (pushOk) mem[wrPtr] <= pushData;
    if (popOk) popData <= mem[rdPtr];
  end

  popNotEmpty: assert property (@(posedge clk) disable iff (!rstn) pop |-> count != '0);

endmodule

// ==== src/dirEntryGen.sv ====
// ------------------------------
// 32 byte short directory entry
// of the log file, byte addressed
// ------------------------------
`timescale 1ns/1ps
`include "sdLogConsts.svh"

module dirEntryGen (
  input  sdLogPkg::byteIdxT entryIdx,
  input  sdLogPkg::clusterT startCluster,
  input  sdLogPkg::sectorT  sectorCount,
  output sdLogPkg::byteT    entryByte
);

  // 8.3 name, first character in the top byte
  localparam logic [8*11-1:0] FileName = `LOG_FILE_NAME;

  logic        inEntry;
  logic [31:0] fileSize;

  assign inEntry  = entryIdx < 9'(`DIR_ENTRY_BYTES);
  // whole sectors only, size = sectors * 512
  assign fileSize = {sectorCount[22:0], 9'd0};

  always_comb begin
    entryByte = '0;
    if (inEntry) begin
      case (entryIdx[4:0])
        5'd11: entryByte = `FILE_ATTR;
        // first cluster, high half
        5'd20: entryByte = startCluster[23:16];
        5'd21: entryByte = startCluster[31:24];
        // first cluster, low half
        5'd26: entryByte = startCluster[7:0];
        5'd27: entryByte = startCluster[15:8];
        // file size, little endian
        5'd28: entryByte = fileSize[7:0];
        5'd29: entryByte = fileSize[15:8];
        5'd30: entryByte = fileSize[23:16];
        5'd31: entryByte = fileSize[31:24];
        default: begin
          // name field, bytes 0..10
          if (entryIdx[4:0] < 5'd11) begin
            entryByte = FileName[8 * (10 - int'(entryIdx[4:0])) +: 8];
          end
        end
      endcase
    end
  end

endmodule

// ==== src/sectorWriteCtrl.sv ====
// ------------------------------
// sector write sequencer
// data sectors from the fifo,
// periodic directory rewrite
// ------------------------------
`timescale 1ns/1ps
`include "sdLogConsts.svh"

module sectorWriteCtrl (
  input  logic              clk,
  input  logic              rstn,
  input  logic              ready,
  input  sdLogPkg::countT   count,
  input  sdLogPkg::byteT    popData,
  output logic              pop,
  input  sdLogPkg::sectorT  dataStartSector,
  input  sdLogPkg::sectorT  dirSector,
  output sdLogPkg::byteIdxT entryIdx,
  input  sdLogPkg::byteT    entryByte,
  output sdLogPkg::sectorT  sectorCount,
  output logic              wrStart,
  output sdLogPkg::sectorT  wrSector,
  output sdLogPkg::byteT    wrByte,
  input  logic              nextByte,
  input  logic              wrDone
);

  localparam sdLogPkg::countT   SectorFill = sdLogPkg::countT'(`SECTOR_BYTES);
  localparam sdLogPkg::byteIdxT LastIdx    = sdLogPkg::byteIdxT'(`SECTOR_BYTES - 1);

  sdLogPkg::ctrlStateT state;
  sdLogPkg::byteIdxT   byteCnt;
  logic                popDly;
  logic                lastByte;
  logic                updateDue;
  logic                launchData;
  logic                launchDir;

  // ------------------------------
  // launch and pop decisions
  // ------------------------------
  assign lastByte   = byteCnt == LastIdx;
  assign updateDue  = (sectorCount % 32'(`UPDATE_EVERY)) == 32'd0;
  assign launchData = (state == sdLogPkg::stIdle) && ready && (count >= SectorFill);
  assign launchDir  = (state == sdLogPkg::stDataEnd) && updateDue && ready;

  // prefetch with wrStart, then one pop per sampled byte
  // no pop after the 512th byte
  assign pop = (state == sdLogPkg::stData) && (wrStart || (nextByte && !lastByte));

  always_ff @(posedge clk or negedge rstn) begin
    if (!rstn) begin
      state       <= sdLogPkg::stIdle;
      wrStart     <= 1'b0;
      popDly      <= 1'b0;
      sectorCount <= '0;
      byteCnt     <= '0;
      entryIdx    <= '0;
    end else begin
      wrStart <= launchData || launchDir;
      popDly  <= pop;
      case (state)
        sdLogPkg::stIdle: begin
          if (launchData) begin
            state   <= sdLogPkg::stData;
            byteCnt <= '0;
          end
        end
        sdLogPkg::stData: begin
          if (nextByte) byteCnt <= byteCnt + 9'd1;
          if (wrDone) begin
            state       <= sdLogPkg::stDataEnd;
            sectorCount <= sectorCount + 32'd1;
          end
        end
        sdLogPkg::stDataEnd: begin
          // wait here for ready when an update is due
          if (!updateDue) begin
            state <= sdLogPkg::stIdle;
          end else if (launchDir) begin
            state    <= sdLogPkg::stDir;
            entryIdx <= '0;
          end
        end
        sdLogPkg::stDir: begin
          if (nextByte) entryIdx <= entryIdx + 9'd1;
          if (wrDone) state <= sdLogPkg::stDirEnd;
        end
        sdLogPkg::stDirEnd: state <= sdLogPkg::stIdle;
        default: state <= sdLogPkg::stIdle;
      endcase
    end
  end

  // ------------------------------
  // address and byte outputs
  // ------------------------------
  always_ff @(posedge clk) begin
    if (launchData) begin
      wrSector <= dataStartSector + sectorCount;
    end else if (launchDir) begin
      wrSector <= dirSector;
    end
    // fifo head is valid one cycle after the pop
    if (popDly) begin
      wrByte <= popData;
    end else if (state == sdLogPkg::stDir) begin
      wrByte <= entryByte;
    end
  end

  wrStartPulse: assert property (@(posedge clk) disable iff (!rstn) wrStart |=> !wrStart);
  wrStartReady: assert property (@(posedge clk) disable iff (!rstn) wrStart |-> $past(ready));

endmodule

// ==== src/fileLogger.sv ====
// ------------------------------
// logger top, uart to sectors
// ------------------------------
`timescale 1ns/1ps

module fileLogger (
  input  logic              clk,
  input  logic              rstn,
  input  logic              rx,
  // write engine strobes
  input  logic              ready,
  input  logic              nextByte,
  input  logic              wrDone,
  // filesystem layout, static levels
  input  sdLogPkg::sectorT  dataStartSector,
  input  sdLogPkg::sectorT  dirSector,
  input  sdLogPkg::clusterT startCluster,
  output logic              wrStart,
  output sdLogPkg::sectorT  wrSector,
  output sdLogPkg::byteT    wrByte,
  output sdLogPkg::sectorT  sectorCount,
  output logic              overflow
);

  sdLogPkg::byteT    rxByte;
  logic              rxValid;
  sdLogPkg::byteT    popData;
  sdLogPkg::countT   count;
  logic              pop;
  sdLogPkg::byteIdxT entryIdx;
  sdLogPkg::byteT    entryByte;

  uartRx iRx (.clk, .rstn, .rx, .rxByte, .rxValid);

  byteFifo iFifo (
    .clk, .rstn, .push(rxValid), .pushData(rxByte), .pop, .popData, .count, .overflow
  );

  dirEntryGen iEntry (.entryIdx, .startCluster, .sectorCount, .entryByte);

  sectorWriteCtrl iCtrl (
    .clk, .rstn, .ready, .count, .popData, .pop,
    .dataStartSector, .dirSector, .entryIdx, .entryByte, .sectorCount,
    .wrStart, .wrSector, .wrByte, .nextByte, .wrDone
  );

endmodule

// ==== tb/tbFileLogger.sv ====
// ------------------------------
// testbench of the logger top
// uart driver, write engine model,
// directory reference, checks
// ------------------------------
`timescale 1ns/1ps
`include "sdLogConsts.svh"

module tbFileLogger;

  localparam int SectorBytes = `SECTOR_BYTES;
  localparam int WaitLimit   = 20000;

  logic              clk = 1'b0;
  logic              rstn;
  logic              rx;
  logic              ready;
  logic              nextByte;
  logic              wrDone;
  sdLogPkg::sectorT  dataStartSector;
  sdLogPkg::sectorT  dirSector;
  sdLogPkg::clusterT startCluster;
  logic              wrStart;
  sdLogPkg::sectorT  wrSector;
  sdLogPkg::byteT    wrByte;
  sdLogPkg::sectorT  sectorCount;
  logic              overflow;

  // sent data, captured sectors, bookkeeping
  sdLogPkg::byteT   sentBytes [$];
  sdLogPkg::sectorT capSector [$];
  sdLogPkg::byteT   capBytes [$];
  event             sectorCaptured;
  int               startCount   = 0;
  int               checkedCount = 0;
  int               dataSeen     = 0;
  bit               expectDir    = 1'b0;
  bit               overflowSeen = 1'b0;
  bit               timedOut     = 1'b0;
  int               errorCount   = 0;
  int               testsRun     = 0;
  int               testsFailed  = 0;

  fileLogger i_dut (
    .clk, .rstn, .rx, .ready, .nextByte, .wrDone,
    .dataStartSector, .dirSector, .startCluster,
    .wrStart, .wrSector, .wrByte, .sectorCount, .overflow
  );

  // 50 MHz
  always #10 clk = ~clk;

  // ------------------------------
  // reference and check helpers
  // ------------------------------
  // expected directory entry byte
  function automatic sdLogPkg::byteT dirEntryRef(input int index,
                                                 input sdLogPkg::clusterT cluster,
                                                 input int sectors);
    string          name;
    logic [31:0]    size;
    sdLogPkg::byteT b;
    name = `LOG_FILE_NAME;
    size = 32'(sectors) * 32'(SectorBytes);
    b = 8'h00;
    if (index < 11) begin
      b = name[index];
    end else begin
      case (index)
        11: b = `FILE_ATTR;
        20: b = cluster[23:16];
        21: b = cluster[31:24];
        26: b = cluster[7:0];
        27: b = cluster[15:8];
        28, 29, 30, 31: b = size[8 * (index - 28) +: 8];
        default: b = 8'h00;
      endcase
    end
    return b;
  endfunction

  task automatic compareValue(input string what, input logic [31:0] got,
                              input logic [31:0] exp);
    if (got !== exp) begin
      errorCount++;
      $display("[ERROR] %0t ns: %s is %0h, expected %0h", $time, what, got, exp);
    end
  endtask

  task automatic reportTest(input string name, input int errBefore);
    testsRun++;
    if (errorCount == errBefore) begin
      $display("test %0d %s: passed", testsRun, name);
    end else begin
      testsFailed++;
      $display("test %0d %s: failed, %0d errors", testsRun, name, errorCount - errBefore);
    end
  endtask

  // poll until n sectors are compared
  task automatic waitChecked(input int n, output bit ok);
    int cycles;
    cycles = 0;
    while (checkedCount < n && cycles < WaitLimit) begin
      @(posedge clk);
      cycles++;
    end
    ok = (checkedCount >= n);
    if (!ok) begin
      timedOut = 1'b1;
      $display("timeout: sector %0d was not written within %0d cycles", n, cycles);
    end
  endtask

  // ------------------------------
  // uart stimulus
  // ------------------------------
  // 8N1 frame with lsb first
  task automatic sendByte(input sdLogPkg::byteT b);
    logic [9:0] frame;
    int         i;
    frame = {1'b1, b, 1'b0};
    for (i = 0; i < 10; i++) begin
      @(posedge clk);
      rx <= frame[i];
      repeat (`CLKS_PER_BIT - 1) @(posedge clk);
    end
  endtask

  task automatic sendRandom(input int n);
    sdLogPkg::byteT b;
    int             i;
    for (i = 0; i < n; i++) begin
      b = sdLogPkg::byteT'($urandom());
      sentBytes.push_back(b);
      sendByte(b);
    end
    // let the last frame reach the fifo
    repeat (2 * `CLKS_PER_BIT) @(posedge clk);
  endtask

  // ------------------------------
  // sd write engine model
  // ------------------------------
  task automatic serveSector();
    int k;
    startCount++;
    capSector.push_back(wrSector);
    for (k = 0; k < SectorBytes; k++) begin
      // byte is settled 2 cycles after the previous strobe
      repeat (3) @(posedge clk);
      capBytes.push_back(wrByte);
      nextByte <= 1'b1;
      @(posedge clk);
      nextByte <= 1'b0;
    end
    wrDone <= 1'b1;
    @(posedge clk);
    wrDone <= 1'b0;
    -> sectorCaptured;
  endtask

  initial begin
    nextByte = 1'b0;
    wrDone   = 1'b0;
    forever begin
      @(posedge clk);
      if (rstn && wrStart) serveSector();
    end
  end

  // ------------------------------
  // sector comparison
  // ------------------------------
  // expected sector kind follows the update period
  task automatic compareSector();
    sdLogPkg::sectorT addr;
    sdLogPkg::sectorT expAddr;
    sdLogPkg::byteT   got;
    sdLogPkg::byteT   exp;
    int               k;
    addr    = capSector.pop_front();
    expAddr = expectDir ? dirSector : dataStartSector + 32'(dataSeen);
    compareValue("sector address", addr, expAddr);
    if (!expectDir && sentBytes.size() < SectorBytes) begin
      errorCount++;
      $display("data sector %0h was written with only %0d bytes sent", addr,
               sentBytes.size());
    end
    for (k = 0; k < SectorBytes; k++) begin
      got = capBytes.pop_front();
      exp = 8'h00;
      if (expectDir) begin
        exp = dirEntryRef(k, startCluster, dataSeen);
      end else if (sentBytes.size() > 0) begin
        exp = sentBytes.pop_front();
      end
      compareValue($sformatf("byte %0d of sector %0h", k, addr), 32'(got), 32'(exp));
    end
    if (expectDir) begin
      expectDir = 1'b0;
    end else begin
      dataSeen++;
      expectDir = (dataSeen % `UPDATE_EVERY) == 0;
    end
    checkedCount++;
  endtask

  always begin
    @(sectorCaptured);
    while (capSector.size() > 0) compareSector();
  end

  // sticky overflow watch
  always @(posedge clk) begin
    if (rstn && overflow) overflowSeen <= 1'b1;
  end

  // ------------------------------
  // test sequence
  // ------------------------------
  task automatic runTests();
    int errBefore;
    bit ok;
    errBefore = errorCount;
    sendRandom(300);
    compareValue("wrStart count", 32'(startCount), 32'd0);
    compareValue("sectorCount", sectorCount, 32'd0);
    reportTest("no write below one sector", errBefore);

    errBefore = errorCount;
    sendRandom(212);
    waitChecked(1, ok);
    if (!ok) return;
    // room for a directory write that must not come
    repeat (200) @(posedge clk);
    compareValue("sectorCount", sectorCount, 32'd1);
    compareValue("wrStart count", 32'(startCount), 32'd1);
    reportTest("first data sector", errBefore);

    errBefore = errorCount;
    @(posedge clk);
    ready <= 1'b0;
    sendRandom(512);
    repeat (100) @(posedge clk);
    compareValue("wrStart count with ready low", 32'(startCount), 32'd1);
    ready <= 1'b1;
    waitChecked(2, ok);
    if (!ok) return;
    reportTest("second sector held by ready", errBefore);

    errBefore = errorCount;
    waitChecked(3, ok);
    if (!ok) return;
    repeat (4) @(posedge clk);
    compareValue("sectorCount", sectorCount, 32'd2);
    reportTest("directory update", errBefore);

    errBefore = errorCount;
    compareValue("overflow seen", 32'(overflowSeen), 32'd0);
    reportTest("no fifo overflow", errBefore);
  endtask

  initial begin
    rstn            = 1'b0;
    rx              = 1'b1;
    ready           = 1'b1;
    dataStartSector = 32'h0000_2040;
    dirSector       = 32'h0000_1f80;
    startCluster    = 32'h0012_3405;
    void'($urandom(29));
    repeat (5) @(posedge clk);
    rstn <= 1'b1;
    runTests();
    $display("tests run %0d, failed %0d, errors %0d", testsRun, testsFailed, errorCount);
    if (errorCount == 0 && testsFailed == 0 && !timedOut && testsRun == 5) begin
      $display("RESULT: PASS");
    end else begin
      $display("RESULT: FAIL");
    end
    $finish;
  end

endmodule

// ==== verilog.f ====
+incdir+src
src/sdLogPkg.sv
src/uartRx.sv
src/byteFifo.sv
src/dirEntryGen.sv
src/sectorWriteCtrl.sv
src/fileLogger.sv
tb/tbFileLogger.sv

// ==== run.sh ====
#!/bin/sh
set -e
cd "$(dirname "$0")"

rm -rf obj_dir sim.log
verilator --binary --timing --assert -Wno-fatal -f verilog.f \
  --top-module tbFileLogger -o simv
./obj_dir/simv > sim.log || true
cat sim.log

if grep -q "^RESULT: PASS$" sim.log; then
  exit 0
fi
echo "simulation did not pass"
exit 1
